//--- compile.f
design/ls_pkg.sv
design/ls_request_decode.sv
design/axi_master.sv
design/load_result_align.sv
design/ls_axi_unit.sv
tests/axi_mem_model.sv
tests/ls_axi_unit_assert.sv
tests/ls_axi_unit_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ls_axi_unit_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/ls_axi_unit_tb.sv
// testbench for the load/store axi unit
// runs a request table against an axi memory model and a shadow memory

`timescale 1ns/1ps

module ls_axi_unit_tb;

    localparam int RESP_DELAY   = 2;
    localparam int RESET_CYCLES = 10;
    localparam int NROWS        = 24;
    localparam int TRIP_MAX     = 2 * RESP_DELAY + 24; // round trip incl. back-pressure
    localparam int CYCLE_LIMIT  = NROWS * TRIP_MAX + RESET_CYCLES + 20;
    localparam logic [31:0] SEED = 32'hf239_3cc9;
    localparam logic LD  = 1'b0;
    localparam logic ST  = 1'b1;
    localparam logic AL  = 1'b0; // aligned access on the bus
    localparam logic MIS = 1'b1; // expect the misaligned pulse

    // op, funct3, misaligned, address, store data
    localparam logic [68:0] STIMULUS [NROWS] = '{
        {LD, ls_pkg::F3_LW,  AL,  32'h0000_0000, 32'h0000_0000},
        {LD, ls_pkg::F3_LB,  AL,  32'h0000_0012, 32'h0000_0000},
        {LD, ls_pkg::F3_LBU, AL,  32'h0000_0011, 32'h0000_0000},
        {LD, ls_pkg::F3_LH,  AL,  32'h0000_0032, 32'h0000_0000},
        {LD, ls_pkg::F3_LHU, AL,  32'h0000_0030, 32'h0000_0000},
        {ST, ls_pkg::F3_SW,  AL,  32'h0000_0050, 32'h80ff_7f01},
        {LD, ls_pkg::F3_LB,  AL,  32'h0000_0050, 32'h0000_0000},
        {LD, ls_pkg::F3_LB,  AL,  32'h0000_0051, 32'h0000_0000},
        {LD, ls_pkg::F3_LB,  AL,  32'h0000_0053, 32'h0000_0000}, // negative byte
        {LD, ls_pkg::F3_LBU, AL,  32'h0000_0052, 32'h0000_0000},
        {LD, ls_pkg::F3_LH,  AL,  32'h0000_0052, 32'h0000_0000},
        {LD, ls_pkg::F3_LHU, AL,  32'h0000_0052, 32'h0000_0000},
        {ST, ls_pkg::F3_SB,  AL,  32'h0000_0061, 32'h0000_00a5},
        {LD, ls_pkg::F3_LW,  AL,  32'h0000_0060, 32'h0000_0000},
        {ST, ls_pkg::F3_SH,  AL,  32'h0000_0072, 32'h1234_8765},
        {LD, ls_pkg::F3_LW,  AL,  32'h0000_0070, 32'h0000_0000},
        {ST, ls_pkg::F3_SB,  AL,  32'h0000_0063, 32'hffff_ff3c},
        {LD, ls_pkg::F3_LW,  AL,  32'h0000_0060, 32'h0000_0000},
        {LD, ls_pkg::F3_LH,  MIS, 32'h0000_0101, 32'h0000_0000},
        {LD, ls_pkg::F3_LW,  MIS, 32'h0000_0102, 32'h0000_0000},
        {ST, ls_pkg::F3_SH,  MIS, 32'h0000_00a3, 32'h5555_5555},
        {ST, ls_pkg::F3_SW,  MIS, 32'h0000_00a1, 32'h6666_6666},
        {LD, ls_pkg::F3_LW,  AL,  32'h0000_00a0, 32'h0000_0000}, // must be untouched
        {LD, ls_pkg::F3_LBU, AL,  32'h0000_03ff, 32'h0000_0000}  // top byte of memory
    };

    logic        clk, rst;
    logic        new_request, load, store;
    logic [2:0]  funct3;
    logic [31:0] addr, store_data;
    logic        ready, load_valid, misaligned;
    logic [31:0] load_data;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic [2:0]  arsize, awsize;
    logic        arvalid, arready, rvalid, rready;
    logic        awvalid, awready, wvalid, wlast, wready, bvalid, bready;
    logic [3:0]  wstrb;
    logic [31:0] shadow [256];     // expected memory contents
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;

    ls_axi_unit dut (
        .clk, .rst, .new_request, .load, .store, .funct3, .addr, .store_data,
        .ready, .load_valid, .load_data, .misaligned,
        .araddr, .arsize, .arvalid, .arready, .rvalid, .rdata, .rready,
        .awaddr, .awsize, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wlast, .wready, .bvalid, .bready
    );

    axi_mem_model #(.RESP_DELAY(RESP_DELAY)) u_mem (
        .clk, .rst, .araddr, .arsize, .arvalid, .arready, .rvalid, .rdata, .rready,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready, .bvalid, .bready
    );

    always #2 clk = ~clk;

    // run limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: requests still pending after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fill_shadow();
        logic [31:0] s;
        s = SEED;
        for (int i = 0; i < 256; i++) begin
            s = xorshift32(s);
            shadow[i] = s;
        end
    endtask

    // pick byte or half at the offset and extend it per funct3 bit 2
    function automatic logic [31:0] expected_load(input logic [2:0] f3, input logic [31:0] a);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = shadow[a[9:2]];
        b    = word[{a[1:0], 3'b000} +: 8];
        h    = word[{a[1], 4'b0000} +: 16];
        if (f3[1:0] == 2'b00) return f3[2] ? {24'h0, b} : {{24{b[7]}}, b};
        if (f3[1:0] == 2'b01) return f3[2] ? {16'h0, h} : {{16{h[15]}}, h};
        return word;
    endfunction

    task automatic update_shadow(input logic [2:0] f3, input logic [31:0] a,
                                 input logic [31:0] d);
        case (f3[1:0])
            2'b00:   shadow[a[9:2]][{a[1:0], 3'b000} +: 8] = d[7:0];
            2'b01:   shadow[a[9:2]][{a[1], 4'b0000} +: 16] = d[15:0];
            default: shadow[a[9:2]] = d;
        endcase
    endtask

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("** Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // address, size, strobes and lane data of the channel just opened
    task automatic verify_channel_fields(input int idx, input logic op, input logic [2:0] f3,
                                         input logic [31:0] a, input logic [31:0] d);
        int         nbytes;
        int         first;
        logic [2:0] sz;
        logic [3:0] strb;
        logic       lanes_ok;
        nbytes   = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
        first    = int'(a[1:0]) & ~(nbytes - 1); // lowest byte lane touched
        sz       = 3'($clog2(nbytes));          // log2 of bytes per beat
        lanes_ok = 1'b1;
        for (int lane = 0; lane < 4; lane++) begin
            strb[lane] = (lane >= first) && (lane < first + nbytes);
            if (strb[lane]) begin
                if (wdata[8*lane +: 8] !== d[8*(lane - first) +: 8]) begin
                    lanes_ok = 1'b0;
                end
            end
        end
        if (op == LD) begin
            check(araddr === a && arsize === sz,
                  $sformatf("row %0d araddr %h arsize %0d", idx, araddr, arsize));
        end else begin
            check(awaddr === a && awsize === sz && wstrb === strb && wlast === 1'b1,
                  $sformatf("row %0d awaddr %h awsize %0d wstrb %b wlast %b", idx, awaddr,
                            awsize, wstrb, wlast));
            check(lanes_ok, $sformatf("row %0d wdata %h lanes differ from %h", idx, wdata, d));
        end
    endtask

    task automatic run_row(input int idx);
        logic [68:0] row;
        logic        op, mis;
        logic [2:0]  f3;
        logic [31:0] a, d, want;
        int          errs_before;
        row = STIMULUS[idx];
        op  = row[68];
        f3  = row[67:65];
        mis = row[64];
        a   = row[63:32];
        d   = row[31:0];
        errs_before = errors;
        while (ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        new_request = 1'b1;
        load        = ~op;
        store       = op;
        funct3      = f3;
        addr        = a;
        store_data  = d;
        @(posedge clk);
        #1;
        new_request = 1'b0;
        load        = 1'b0;
        store       = 1'b0;
        if (mis) begin
            check(misaligned === 1'b1, $sformatf("row %0d misaligned pulse missing", idx));
            check(!arvalid && !awvalid && !wvalid,
                  $sformatf("row %0d bus valid raised on misaligned access", idx));
            check(ready === 1'b1, $sformatf("row %0d ready dropped on misaligned", idx));
        end else if (op == LD) begin
            check(arvalid === 1'b1 && ready === 1'b0 && misaligned === 1'b0,
                  $sformatf("row %0d load not started, arvalid %b ready %b", idx, arvalid,
                            ready));
            verify_channel_fields(idx, op, f3, a, d);
            want = expected_load(f3, a);
            while (load_valid !== 1'b1) begin
                @(posedge clk);
                #1;
            end
            check(load_data === want,
                  $sformatf("row %0d load_data %h, expected %h", idx, load_data, want));
            check(ready === 1'b1, $sformatf("row %0d ready low with load_valid", idx));
        end else begin
            check(awvalid === 1'b1 && wvalid === 1'b1 && ready === 1'b0 && misaligned === 1'b0,
                  $sformatf("row %0d store not started, awvalid %b wvalid %b", idx, awvalid,
                            wvalid));
            verify_channel_fields(idx, op, f3, a, d);
            while (ready !== 1'b1) begin
                @(posedge clk);
                #1;
            end
            update_shadow(f3, a, d); // memory holds it once the response came back
        end
        $display("row %0d %s f3 %0d addr %h: %s", idx, op ? "store" : "load", f3, a,
                 (errors == errs_before) ? "ok" : "bad");
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        new_request = 1'b0;
        load        = 1'b0;
        store       = 1'b0;
        funct3      = 3'b000;
        addr        = 32'h0;
        store_data  = 32'h0;
        fill_shadow();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        check(ready === 1'b1, "ready not high after reset");
        check(load_valid === 1'b0 && misaligned === 1'b0, "load_valid or misaligned after reset");
        check(rready === 1'b1 && bready === 1'b1, "rready or bready not held high");
        for (int i = 0; i < NROWS; i++) begin
            run_row(i);
        end
        $display("checks run %0d, failed %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- tests/ls_axi_unit_assert.sv
// protocol assertions for the axi master
// valid hold rules, request legality and the ready state after reset

`timescale 1ns/1ps

module ls_axi_unit_assert (
    input logic clk,
    input logic rst,
    input logic issue,
    input logic ready,
    input logic arvalid,
    input logic arready,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready
);

    // each valid stays up until its ready is seen
    assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");
    assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");
    assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    // one transaction at a time
    assert property (@(posedge clk) disable iff (rst) !ready |-> !issue)
        else $error("issue while a transaction is pending");

    assert property (@(posedge clk) $fell(rst) |-> ready)
        else $error("ready low after reset");

endmodule

bind axi_master ls_axi_unit_assert u_assert (
    .clk(clk), .rst(rst), .issue(issue), .ready(ready),
    .arvalid(arvalid), .arready(arready), .awvalid(awvalid), .awready(awready),
    .wvalid(wvalid), .wready(wready)
);

//--- tests/axi_mem_model.sv
// axi slave memory model for the load/store unit testbench
// 256-word byte-strobed memory, fixed response delay, random ready back-pressure

`timescale 1ns/1ps

module axi_mem_model #(
    parameter int RESP_DELAY = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic [2:0]  arsize,
    input  logic        arvalid,
    output logic        arready,
    output logic        rvalid,
    output logic [31:0] rdata,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready
);

    localparam logic [31:0] SEED = 32'hf239_3cc9;

    logic [31:0] mem [256];
    logic [31:0] rnd;           // back-pressure and junk lane source
    logic [31:0] rd_addr;
    logic [2:0]  rd_size;
    logic        rd_busy;
    int          rd_cnt;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        aw_got;        // write address taken
    logic        w_got;         // write data taken
    logic        wr_busy;
    int          wr_cnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // bytes that carry real data for a read of this size and offset
    function automatic logic [31:0] lane_mask(input logic [2:0] sz, input logic [1:0] off);
        case (sz)
            ls_pkg::AXI_SIZE_BYTE: return 32'h0000_00ff << {off, 3'b000};
            ls_pkg::AXI_SIZE_HALF: return 32'h0000_ffff << {off, 3'b000};
            default:               return 32'hffff_ffff;
        endcase
    endfunction

    initial begin
        logic [31:0] s;
        s = SEED;
        for (int i = 0; i < 256; i++) begin
            s = xorshift32(s);
            mem[i] = s; // same sequence as the testbench shadow
        end
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        bvalid  = 1'b0;
        rdata   = 32'h0;
    end

    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            rd_cnt  <= 0;
            wr_cnt  <= 0;
            rnd     <= ~SEED;
        end else begin
            rnd     <= xorshift32(rnd);
            arready <= rnd[3];  // toggles freely, master must hold valid
            awready <= rnd[7];
            wready  <= rnd[11];

            // read: address handshake, wait, then one data beat
            if (rvalid && rready) rvalid <= 1'b0;
            if (arvalid && arready) begin
                rd_addr <= araddr;
                rd_size <= arsize;
                rd_cnt  <= RESP_DELAY;
                rd_busy <= 1'b1;
            end else if (rd_busy && rd_cnt != 0) begin
                rd_cnt <= rd_cnt - 1;
            end else if (rd_busy) begin
                rvalid  <= 1'b1;
                rdata   <= (mem[rd_addr[9:2]] & lane_mask(rd_size, rd_addr[1:0]))
                         | (rnd & ~lane_mask(rd_size, rd_addr[1:0])); // junk in idle lanes
                rd_busy <= 1'b0;
            end

            // write: address and data in any order, then the response
            if (bvalid && bready) bvalid <= 1'b0;
            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                wr_addr <= awaddr;
            end
            if (wvalid && wready) begin
                w_got   <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
            end
            if (aw_got && w_got) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (wr_strb[lane]) mem[wr_addr[9:2]][8*lane +: 8] = wr_data[8*lane +: 8];
                end
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
                wr_cnt  <= RESP_DELAY;
                wr_busy <= 1'b1;
            end else if (wr_busy && wr_cnt != 0) begin
                wr_cnt <= wr_cnt - 1;
            end else if (wr_busy) begin
                bvalid  <= 1'b1;
                wr_busy <= 1'b0;
            end
        end
    end

endmodule

//--- design/ls_axi_unit.sv
// load/store external bus unit
// joins request decode, the axi master and load result alignment

`timescale 1ns/1ps

module ls_axi_unit (
    input  logic                     clk,
    input  logic                     rst,
    // request side
    input  logic                     new_request,
    input  logic                     load,
    input  logic                     store,
    input  logic [2:0]               funct3,
    input  logic [ls_pkg::XLEN-1:0]  addr,
    input  logic [ls_pkg::XLEN-1:0]  store_data,
    output logic                     ready,
    output logic                     load_valid,
    output logic [ls_pkg::XLEN-1:0]  load_data,
    output logic                     misaligned,
    // axi read
    output logic [ls_pkg::XLEN-1:0]  araddr,
    output logic [2:0]               arsize,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic                     rvalid,
    input  logic [ls_pkg::XLEN-1:0]  rdata,
    output logic                     rready,
    // axi write
    output logic [ls_pkg::XLEN-1:0]  awaddr,
    output logic [2:0]               awsize,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [ls_pkg::XLEN-1:0]  wdata,
    output logic [3:0]               wstrb,
    output logic                     wvalid,
    output logic                     wlast,
    input  logic                     wready,
    input  logic                     bvalid,
    output logic                     bready
);

    logic                    issue;
    logic                    misaligned_now;
    logic [3:0]              be;
    logic [2:0]              size;
    logic [ls_pkg::XLEN-1:0] lane_data;
    logic                    data_valid;
    logic [ls_pkg::XLEN-1:0] data_out;

    ls_request_decode u_decode (
        .new_request, .load, .store, .funct3, .addr, .store_data,
        .issue, .misaligned_now, .be, .size, .lane_data
    );

    axi_master u_master (
        .clk, .rst, .issue, .load, .store, .addr, .be, .size, .lane_data,
        .ready, .data_valid, .data_out,
        .araddr, .arsize, .arvalid, .arready, .rvalid, .rdata, .rready,
        .awaddr, .awsize, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wlast, .wready, .bvalid, .bready
    );

    // offset comes straight from the request address
    load_result_align u_align (
        .clk, .rst, .issue, .misaligned_now, .funct3,
        .addr_low   (addr[1:0]),
        .data_valid, .data_out, .load_valid, .load_data, .misaligned
    );

endmodule

//--- design/load_result_align.sv
// load result alignment
// shifts the returned word down to the accessed byte offset and
// sign- or zero-extends bytes and halfwords, also times the misaligned flag

`timescale 1ns/1ps

module load_result_align (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue,
    input  logic                     misaligned_now,
    input  logic [2:0]               funct3,
    input  logic [1:0]               addr_low,
    input  logic                     data_valid,
    input  logic [ls_pkg::XLEN-1:0]  data_out,
    output logic                     load_valid,
    output logic [ls_pkg::XLEN-1:0]  load_data,
    output logic                     misaligned
);

    logic [2:0]              width_q;   // funct3 of the pending load
    logic [1:0]              offset_q;  // byte offset in the word
    logic [ls_pkg::XLEN-1:0] shifted;

    always_ff @(posedge clk) begin
        if (issue) begin
            width_q  <= funct3;
            offset_q <= addr_low;
        end
    end

    // misaligned shows one cycle after the request, like the bus path
    always_ff @(posedge clk) begin
        if (rst) misaligned <= 1'b0;
        else misaligned <= misaligned_now;
    end

    assign shifted = data_out >> {offset_q, 3'b000}; // wanted byte to lane 0

    always_comb begin
        case (width_q)
            ls_pkg::F3_LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
            ls_pkg::F3_LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
            ls_pkg::F3_LBU: load_data = {24'b0, shifted[7:0]};
            ls_pkg::F3_LHU: load_data = {16'b0, shifted[15:0]};
            default:        load_data = shifted; // lw, offset is zero
        endcase
    end

    assign load_valid = data_valid; // no extra stage

endmodule

//--- design/axi_master.sv
// single-beat axi4 master for the load/store unit
// holds one request at a time, drives ar or aw/w and waits for r or b

`timescale 1ns/1ps

module axi_master (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue,
    input  logic                     load,
    input  logic                     store,
    input  logic [ls_pkg::XLEN-1:0]  addr,
    input  logic [3:0]               be,
    input  logic [2:0]               size,
    input  logic [ls_pkg::XLEN-1:0]  lane_data,
    output logic                     ready,
    output logic                     data_valid,
    output logic [ls_pkg::XLEN-1:0]  data_out,
    // read address and data
    output logic [ls_pkg::XLEN-1:0]  araddr,
    output logic [2:0]               arsize,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic                     rvalid,
    input  logic [ls_pkg::XLEN-1:0]  rdata,
    output logic                     rready,
    // write address, data and response
    output logic [ls_pkg::XLEN-1:0]  awaddr,
    output logic [2:0]               awsize,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [ls_pkg::XLEN-1:0]  wdata,
    output logic [3:0]               wstrb,
    output logic                     wvalid,
    output logic                     wlast,
    input  logic                     wready,
    input  logic                     bvalid,
    output logic                     bready
);

    assign rready = 1'b1; // never stall read data
    assign bready = 1'b1; // nor the write response

    // request payload, loaded on issue
    always_ff @(posedge clk) begin
        if (issue) begin
            araddr <= addr;
            awaddr <= addr;
            arsize <= size;
            awsize <= size;
            wdata  <= lane_data;
            wstrb  <= be;
        end
    end

    // one transaction in flight, ready low until the response
    always_ff @(posedge clk) begin
        if (rst) ready <= 1'b1;
        else if (issue) ready <= 1'b0;
        else if (rvalid | bvalid) ready <= 1'b1;
    end

    // read channel
    always_ff @(posedge clk) begin
        if (rst) arvalid <= 1'b0;
        else if (issue & load) arvalid <= 1'b1;
        else if (arready) arvalid <= 1'b0; // held until accepted
    end

    always_ff @(posedge clk) begin
        if (rst) data_valid <= 1'b0;
        else data_valid <= rvalid; // one-cycle pulse with data_out
    end

    always_ff @(posedge clk) begin
        if (rvalid) data_out <= rdata;
    end

    // write address and data go out together, may be accepted apart
    always_ff @(posedge clk) begin
        if (rst) awvalid <= 1'b0;
        else if (issue & store) awvalid <= 1'b1;
        else if (awready) awvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) wvalid <= 1'b0;
        else if (issue & store) wvalid <= 1'b1;
        else if (wready) wvalid <= 1'b0;
    end

    assign wlast = wvalid; // single beat, every beat is the last

endmodule

//--- design/ls_request_decode.sv
// request decode for the load/store bus path
// builds byte enables, axi size and lane data from funct3 and address,
// and flags misaligned halfword and word accesses

`timescale 1ns/1ps

module ls_request_decode (
    input  logic                     new_request,
    input  logic                     load,
    input  logic                     store,
    input  logic [2:0]               funct3,
    input  logic [ls_pkg::XLEN-1:0]  addr,
    input  logic [ls_pkg::XLEN-1:0]  store_data,
    output logic                     issue,
    output logic                     misaligned_now,
    output logic [3:0]               be,
    output logic [2:0]               size,
    output logic [ls_pkg::XLEN-1:0]  lane_data
);

    logic access;   // a real load or store this cycle
    logic bad_align;

    assign access = new_request & (load | store);

    // only funct3[1:0] sets the width, bit 2 is signedness
    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                size      = ls_pkg::AXI_SIZE_BYTE;
                be        = 4'b0001 << addr[1:0];
                lane_data = {4{store_data[7:0]}}; // byte in every lane
                bad_align = 1'b0; // bytes never misalign
            end
            2'b01: begin
                size      = ls_pkg::AXI_SIZE_HALF;
                be        = 4'b0011 << {addr[1], 1'b0};
                lane_data = {2{store_data[15:0]}};
                bad_align = addr[0];
            end
            default: begin
                // word access, also covers the unused 2'b11 code
                size      = ls_pkg::AXI_SIZE_WORD;
                be        = 4'b1111;
                lane_data = store_data;
                bad_align = |addr[1:0];
            end
        endcase
    end

    // misaligned requests never reach the bus
    assign misaligned_now = access & bad_align;
    assign issue          = access & ~bad_align;

endmodule

//--- design/ls_pkg.sv
// load/store unit shared definitions
// funct3 width codes, axi size codes and the data path width

package ls_pkg;

    // data and address width
    localparam int XLEN = 32;

    // load funct3 codes, bit 2 set means zero-extend
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100; // unsigned byte
    localparam logic [2:0] F3_LHU = 3'b101; // unsigned half

    // store funct3 codes
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // axi size encoding, bytes per beat as log2
    localparam logic [2:0] AXI_SIZE_BYTE = 3'd0;
    localparam logic [2:0] AXI_SIZE_HALF = 3'd1;
    localparam logic [2:0] AXI_SIZE_WORD = 3'd2;

endpackage
